/* rtl/fifo_demo_defines.svh */
// FIFO demo sizes
`ifndef FIFO_DEMO_DEFINES_SVH
`define FIFO_DEMO_DEFINES_SVH

// --------------------
// data path

// payload width of one FIFO entry
`define FIFO_WIDTH   4

// number of flip-flop entries
`define FIFO_DEPTH   5

// pointers and occupancy count, must hold FIFO_DEPTH
`define PTR_WIDTH    3

// --------------------
// timing

// clock cycles per key sampling tick, raise on the board
`define TICK_DIV     16

// clock cycles per display digit step
`define SCAN_DIV     4

// digits on the multiplexed display
`define DIGIT_COUNT  4

`endif

/* rtl/fifo_demo_pkg.sv */
// FIFO demo types
`include "fifo_demo_defines.svh"

package fifo_demo_pkg;

    // --------------------
    // types

    // one FIFO payload
    typedef logic [`FIFO_WIDTH - 1:0]  data_t;

    // read or write pointer, also the occupancy count
    typedef logic [`PTR_WIDTH - 1:0]   ptr_t;

    // segments a..g plus the dot, a is the msb
    typedef logic [7:0]                seg_t;

    // one-hot digit enables, digit 0 is the rightmost
    typedef logic [`DIGIT_COUNT - 1:0] digit_t;

    // --------------------
    // constants

    // scrambled write values, one per push
    localparam data_t PATTERN_TABLE [0:2 ** `FIFO_WIDTH - 1] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // top bar for full, bottom bar for empty
    localparam seg_t SIGN_FULL  = 8'b1000_0000;
    localparam seg_t SIGN_EMPTY = 8'b0001_0000;

endpackage

/* rtl/key_sampler.sv */
// Key sampler
`timescale 1ns/1ps
`include "fifo_demo_defines.svh"

module key_sampler
(
    input  logic clk,
    input  logic reset,
    input  logic push_key,
    input  logic pop_key,
    output logic push_req,
    output logic pop_req
);

    localparam int TICK_W = $clog2(`TICK_DIV);

    // two-flop synchronizers, bit 1 is push, bit 0 is pop
    logic [1:0] sync_a;
    logic [1:0] sync_b;
    // key levels captured at the previous tick
    logic [1:0] last_level;
    logic [TICK_W - 1:0] tick_cnt;
    logic tick;

    // --------------------
    // synchronizer and tick divider
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sync_a     <= '0;
            sync_b     <= '0;
            last_level <= '0;
            tick_cnt   <= '0;
        end
        else
        begin
            sync_a <= {push_key, pop_key};
            sync_b <= sync_a;
            // wraps every TICK_DIV cycles
            if (tick)
                tick_cnt <= '0;
            else
                tick_cnt <= tick_cnt + 1'b1;
            // only look at the keys on a tick, slow enough to skip bounce
            if (tick)
                last_level <= sync_b;
        end
    end

    assign tick = (tick_cnt == TICK_W'(`TICK_DIV - 1));

    // rising level between two ticks gives one strobe
    assign push_req = tick & sync_b[1] & ~last_level[1];
    assign pop_req  = tick & sync_b[0] & ~last_level[0];

endmodule

/* rtl/pattern_source.sv */
// Write pattern source
`timescale 1ns/1ps
`include "fifo_demo_defines.svh"

module pattern_source
    import fifo_demo_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  pushed,
    output data_t write_data
);

    // --------------------
    // table index

    // one index per table entry, wraps at the table size by itself
    logic [`FIFO_WIDTH - 1:0] index;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            index <= '0;
        end
        else if (pushed)
        begin
            // step only when the FIFO took the current value
            index <= index + 1'b1;
        end
    end

    // --------------------
    // table read

    // combinational lookup, first value after reset is 2
    assign write_data = PATTERN_TABLE[index];

endmodule

/* rtl/ff_fifo.sv */
// Flip-flop FIFO
`timescale 1ns/1ps
`include "fifo_demo_defines.svh"

module ff_fifo
    import fifo_demo_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  push_req,
    input  logic  pop_req,
    input  data_t write_data,
    output data_t read_data,
    output ptr_t  wr_ptr,
    output ptr_t  rd_ptr,
    output ptr_t  count,
    output logic  empty,
    output logic  full,
    output logic  pushed
);

    localparam ptr_t LAST_PTR = ptr_t'(`FIFO_DEPTH - 1);
    localparam ptr_t FULL_CNT = ptr_t'(`FIFO_DEPTH);

    // entry storage in flip-flops
    data_t mem [`FIFO_DEPTH];

    logic push_ok;
    logic pop_ok;

    // --------------------
    // accept logic

    // requests against full or empty are simply dropped
    assign push_ok = push_req & ~full;
    assign pop_ok  = pop_req & ~empty;

    // tells the pattern source to move on
    assign pushed = push_ok;

    // --------------------
    // storage write
    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr] <= write_data;
    end

    // --------------------
    // pointers and count
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                // wrap at the depth rather than the pointer width
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------
    // outputs

    // head of the queue is valid only when not empty
    assign read_data = mem[rd_ptr];

    // flags straight from the count register
    assign empty = (count == '0);
    assign full  = (count == FULL_CNT);

endmodule

/* rtl/display_mux.sv */
// Seven-segment display multiplexer
`timescale 1ns/1ps
`include "fifo_demo_defines.svh"

module display_mux
    import fifo_demo_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  data_t  write_data,
    input  data_t  read_data,
    input  ptr_t   wr_ptr,
    input  ptr_t   rd_ptr,
    input  logic   empty,
    input  logic   full,
    output seg_t   abcdefgh,
    output digit_t digit
);

    localparam int SCAN_W = $clog2(`SCAN_DIV);

    logic [SCAN_W - 1:0] scan_cnt;
    data_t nibble;
    seg_t hex_seg;

    // hex digit to segments, dot always off
    function automatic seg_t hex_to_seg(input data_t value);
        seg_t seg;
        case (value)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;
        endcase
        return seg;
    endfunction

    // --------------------
    // digit scan
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            scan_cnt <= '0;
            digit    <= digit_t'(1);
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;
            // rotate left once per SCAN_DIV cycles
            if (scan_cnt == SCAN_W'(`SCAN_DIV - 1))
                digit <= {digit[`DIGIT_COUNT - 2:0], digit[`DIGIT_COUNT - 1]};
        end
    end

    // --------------------
    // nibble select, left to right: wdata, wptr, rptr, rdata
    always_comb
    begin
        if (digit[3])
            nibble = write_data;
        else if (digit[2])
            nibble = data_t'(wr_ptr);
        else if (digit[1])
            nibble = data_t'(rd_ptr);
        else
            nibble = read_data;
    end

    assign hex_seg = hex_to_seg(nibble);

    // --------------------
    // status signs take over the outer digits
    always_comb
    begin
        if (digit[0] & empty)
            abcdefgh = SIGN_EMPTY;
        else if (digit[3] & full)
            abcdefgh = SIGN_FULL;
        else
            abcdefgh = hex_seg;
    end

endmodule

/* rtl/fifo_demo_top.sv */
// FIFO demo top level
`timescale 1ns/1ps

module fifo_demo_top
    import fifo_demo_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] key,
    output logic [7:0] led,
    output seg_t       abcdefgh,
    output digit_t     digit
);

    // --------------------
    // internal wires

    logic  push_req;
    logic  pop_req;
    logic  pushed;
    data_t write_data;
    data_t read_data;
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    ptr_t  count;
    logic  empty;
    logic  full;

    // --------------------
    // request path

    // left key pushes, right key pops
    key_sampler u_key_sampler (
        .clk      (clk),
        .reset    (reset),
        .push_key (key[1]),
        .pop_key  (key[0]),
        .push_req (push_req),
        .pop_req  (pop_req)
    );

    pattern_source u_pattern_source (
        .clk        (clk),
        .reset      (reset),
        .pushed     (pushed),
        .write_data (write_data)
    );

    ff_fifo u_ff_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_req   (push_req),
        .pop_req    (pop_req),
        .write_data (write_data),
        .read_data  (read_data),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr),
        .count      (count),
        .empty      (empty),
        .full       (full),
        .pushed     (pushed)
    );

    // --------------------
    // display and LEDs

    display_mux u_display_mux (
        .clk        (clk),
        .reset      (reset),
        .write_data (write_data),
        .read_data  (read_data),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr),
        .empty      (empty),
        .full       (full),
        .abcdefgh   (abcdefgh),
        .digit      (digit)
    );

    // full on led 7, empty on led 6, count on the low three
    assign led = {full, empty, 3'b000, count};

endmodule

/* verif/fifo_demo_checker.sv */
// FIFO demo checker
`timescale 1ns/1ps
`include "fifo_demo_defines.svh"

module fifo_demo_checker
    import fifo_demo_pkg::*;
(
    input  logic        clk,
    input  logic [7:0]  led,
    input  seg_t        abcdefgh,
    input  digit_t      digit,
    input  logic        check_req,
    input  logic [95:0] row_name,
    input  logic [1:0]  row_op,
    input  ptr_t        exp_count,
    input  logic        exp_empty,
    input  logic        exp_full,
    input  ptr_t        exp_wr,
    input  ptr_t        exp_rd,
    output logic        check_done,
    output int          test_count,
    output int          error_count
);

    // common hex font, segment a in the msb, dot dark
    localparam seg_t HEX_FONT [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    // reference queue, head at index 0
    data_t      model_q [$];
    // next table slot, 4 bits so it wraps at 16
    logic [3:0] pattern_idx;

    function automatic int compare_byte(input string what, input logic [7:0] expected,
                                        input logic [7:0] actual);
        if (expected === actual)
            return 0;
        $display("Mismatch %s %s: expected %h, actual %h", row_name, what, expected, actual);
        return 1;
    endfunction

    // --------------------
    // one row: update the model, then look at led and one full scan
    task automatic check_row();
        logic       push_ok;
        logic       pop_ok;
        seg_t       expected [`DIGIT_COUNT];
        seg_t       captured [`DIGIT_COUNT];
        logic [3:0] seen;
        int         cycles;
        int         d;
        int         row_errors;
        // op bit 1 is push and bit 0 is pop, both judged before either moves
        push_ok = row_op[1] && (model_q.size() < `FIFO_DEPTH);
        pop_ok  = row_op[0] && (model_q.size() > 0);
        if (pop_ok)
            void'(model_q.pop_front());
        if (push_ok)
        begin
            model_q.push_back(PATTERN_TABLE[pattern_idx]);
            pattern_idx = pattern_idx + 4'd1;
        end
        expected[3] = (model_q.size() == `FIFO_DEPTH) ? SIGN_FULL
                                                      : HEX_FONT[PATTERN_TABLE[pattern_idx]];
        expected[2] = HEX_FONT[exp_wr];
        expected[1] = HEX_FONT[exp_rd];
        expected[0] = (model_q.size() == 0) ? SIGN_EMPTY : HEX_FONT[model_q[0]];
        seen = '0;
        @(negedge clk);
        row_errors = compare_byte("led", {exp_full, exp_empty, 3'b000, exp_count}, led);
        // two scan rounds is plenty to meet every digit once
        for (cycles = 0; cycles < 2 * `DIGIT_COUNT * `SCAN_DIV && seen != 4'hf; cycles++)
        begin
            @(negedge clk);
            for (d = 0; d < `DIGIT_COUNT; d++)
            begin
                if (digit == digit_t'(1 << d))
                begin
                    captured[d] = abcdefgh;
                    seen[d]     = 1'b1;
                end
            end
        end
        if (seen != 4'hf)
        begin
            $display("%s: the display scan did not reach every digit", row_name);
            row_errors++;
        end
        for (d = 0; d < `DIGIT_COUNT; d++)
            if (seen[d])
                row_errors += compare_byte($sformatf("digit %0d", d), expected[d], captured[d]);
        test_count++;
        error_count += row_errors;
        if (row_errors == 0)
            $display("test %s: ok", row_name);
        else
            $display("test %s: %0d failed checks", row_name, row_errors);
    endtask

    // --------------------
    // request and done handshake with the stimulus loop
    initial
    begin
        check_done  = 1'b0;
        test_count  = 0;
        error_count = 0;
        pattern_idx = '0;
        forever
        begin
            @(posedge clk);
            if (check_req)
            begin
                check_row();
                check_done = 1'b1;
                wait (!check_req);
                check_done = 1'b0;
            end
        end
    end

endmodule

/* verif/fifo_demo_tb.sv */
// FIFO demo testbench
`timescale 1ns/1ps
`include "fifo_demo_defines.svh"

module fifo_demo_tb
    import fifo_demo_pkg::*;
();

    // key pattern per op, bit 1 push and bit 0 pop
    localparam logic [1:0] OP_IDLE = 2'b00;
    localparam logic [1:0] OP_POP  = 2'b01;
    localparam logic [1:0] OP_PUSH = 2'b10;
    localparam logic [1:0] OP_BOTH = 2'b11;

    localparam int ROWS = 27;
    // hold, release, longest gap and one display scan, rounded up
    localparam int ROW_CYCLES = 9 * `TICK_DIV;

    typedef struct packed {
        logic [95:0] name;
        logic [1:0]  op;
        ptr_t        count;
        logic        empty;
        logic        full;
        ptr_t        wr;
        ptr_t        rd;
    } row_t;

    logic       clk;
    logic       reset;
    logic [1:0] key;
    logic [7:0] led;
    seg_t       abcdefgh;
    digit_t     digit;
    logic       check_req;
    logic       check_done;
    int         test_count;
    int         error_count;
    row_t       rows [ROWS];
    row_t       cur;
    int         n_rows;
    int         i;
    int         gap;
    int         seed;

    fifo_demo_top u_fifo_demo_top (
        .clk      (clk),
        .reset    (reset),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    fifo_demo_checker u_checker (
        .clk         (clk),
        .led         (led),
        .abcdefgh    (abcdefgh),
        .digit       (digit),
        .check_req   (check_req),
        .row_name    (cur.name),
        .row_op      (cur.op),
        .exp_count   (cur.count),
        .exp_empty   (cur.empty),
        .exp_full    (cur.full),
        .exp_wr      (cur.wr),
        .exp_rd      (cur.rd),
        .check_done  (check_done),
        .test_count  (test_count),
        .error_count (error_count)
    );

    // --------------------
    // stimulus table
    task automatic add_row(input logic [95:0] name, input logic [1:0] op, input int count,
                           input logic empty, input logic full, input int wr, input int rd);
        rows[n_rows] = '{name, op, ptr_t'(count), empty, full, ptr_t'(wr), ptr_t'(rd)};
        n_rows++;
    endtask

    task automatic load_table();
        n_rows = 0;
        //      name           op       cnt  e  f  wr rd
        add_row("after_reset", OP_IDLE, 0, 1, 0, 0, 0);
        add_row("push_1",      OP_PUSH, 1, 0, 0, 1, 0);
        add_row("push_2",      OP_PUSH, 2, 0, 0, 2, 0);
        add_row("push_3",      OP_PUSH, 3, 0, 0, 3, 0);
        add_row("push_4",      OP_PUSH, 4, 0, 0, 4, 0);
        add_row("push_5",      OP_PUSH, 5, 0, 1, 0, 0);
        add_row("push_full",   OP_PUSH, 5, 0, 1, 0, 0);
        add_row("pop_1",       OP_POP,  4, 0, 0, 0, 1);
        add_row("pop_2",       OP_POP,  3, 0, 0, 0, 2);
        add_row("pop_3",       OP_POP,  2, 0, 0, 0, 3);
        add_row("pop_4",       OP_POP,  1, 0, 0, 0, 4);
        add_row("pop_5",       OP_POP,  0, 1, 0, 0, 0);
        add_row("pop_empty",   OP_POP,  0, 1, 0, 0, 0);
        add_row("refill_1",    OP_PUSH, 1, 0, 0, 1, 0);
        add_row("refill_2",    OP_PUSH, 2, 0, 0, 2, 0);
        // count holds while both pointers walk past the wrap
        add_row("both_1",      OP_BOTH, 2, 0, 0, 3, 1);
        add_row("both_2",      OP_BOTH, 2, 0, 0, 4, 2);
        add_row("both_3",      OP_BOTH, 2, 0, 0, 0, 3);
        add_row("both_4",      OP_BOTH, 2, 0, 0, 1, 4);
        add_row("both_5",      OP_BOTH, 2, 0, 0, 2, 0);
        add_row("both_6",      OP_BOTH, 2, 0, 0, 3, 1);
        add_row("both_7",      OP_BOTH, 2, 0, 0, 4, 2);
        add_row("both_8",      OP_BOTH, 2, 0, 0, 0, 3);
        add_row("both_9",      OP_BOTH, 2, 0, 0, 1, 4);
        // 17th accepted push takes the first table value again
        add_row("push_wrap",   OP_PUSH, 3, 0, 0, 2, 4);
        add_row("idle_hold",   OP_IDLE, 3, 0, 0, 2, 4);
        add_row("pop_final",   OP_POP,  2, 0, 0, 2, 0);
    endtask

    // long enough hold and release for exactly one strobe per press
    task automatic press_keys(input logic [1:0] op);
        key = op;
        repeat (2 * `TICK_DIV) @(negedge clk);
        key = 2'b00;
        repeat (2 * `TICK_DIV) @(negedge clk);
    endtask

    // --------------------
    // clock and watchdog
    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    initial
    begin
        #(ROWS * ROW_CYCLES * 8 + 1000);
        $display("timeout: the row sequence did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    // --------------------
    // main sequence
    initial
    begin
        reset     = 1'b1;
        key       = 2'b00;
        check_req = 1'b0;
        cur       = '0;
        seed      = 32'h4f7e_d376;
        load_table();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (i = 0; i < n_rows; i++)
        begin
            cur = rows[i];
            press_keys(cur.op);
            check_req = 1'b1;
            wait (check_done);
            @(negedge clk);
            check_req = 1'b0;
            wait (!check_done);
            gap = $unsigned($random(seed)) % 4;
            repeat (gap * `TICK_DIV) @(negedge clk);
        end
        $display("tests %0d, failed checks %0d", test_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/fifo_demo_pkg.sv
rtl/key_sampler.sv
rtl/pattern_source.sv
rtl/ff_fifo.sv
rtl/display_mux.sv
rtl/fifo_demo_top.sv
verif/fifo_demo_checker.sv
verif/fifo_demo_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the FIFO demo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f \
    --top-module fifo_demo_tb -Mdir obj_dir -o fifo_demo_sim

./obj_dir/fifo_demo_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
